// File: hw/emesh_pkg.sv
// mesh network packet package with field widths and the 104-bit packet layout
`default_nettype none

package emesh_pkg;

   // address and data widths of the mesh
   localparam int AW = 32;
   localparam int DW = 32;

   // transfer size and control field widths
   localparam int DMW = 2;
   localparam int CMW = 4;

   // mesh address, upper 12 bits are the chip identifier
   typedef logic [AW-1:0] addr_t;

   // one data word
   typedef logic [DW-1:0] data_t;

   // transfer size, byte to double word
   typedef logic [DMW-1:0] datamode_t;

   // routing and special transaction control
   typedef logic [CMW-1:0] ctrlmode_t;

   // full mesh packet, write bit at bit 0
   // srcaddr doubles as upper data word on 64-bit writes
   typedef struct packed {
      // bits 103:72
      addr_t     srcaddr;
      // bits 71:40
      data_t     data;
      // bits 39:8
      addr_t     dstaddr;
      // bit 7, spare, carried through on forward
      logic      rsvd;
      // bits 6:3
      ctrlmode_t ctrlmode;
      // bits 2:1
      datamode_t datamode;
      // bit 0, 1 for write, 0 for read request
      logic      write;
   } emesh_packet_t;

endpackage

`default_nettype wire

// File: hw/ecfg_regmap_pkg.sv
// link configuration space package with address groups, chip id and register map
`default_nettype none

package ecfg_regmap_pkg;

   // register bus widths
   localparam int MI_AW = 15;
   localparam int MI_DW = 64;

   // register offset, low 15 bits of the mesh address
   typedef logic [MI_AW-1:0] mi_addr_t;

   // register bus word, srcaddr in 63:32 and data in 31:0
   typedef logic [MI_DW-1:0] mi_data_t;

   // request from the decoder to every register block
   typedef struct packed {
      logic     we;
      mi_addr_t addr;
      mi_data_t din;
   } mi_req_t;

   // chip identifier, dstaddr bits 31:20
   typedef logic [11:0] chip_id_t;
   localparam chip_id_t CHIP_ID = 12'h810;

   // address group, dstaddr bits 19:16
   typedef logic [3:0] group_t;
   localparam group_t GROUP_MMR = 4'hF;
   localparam group_t GROUP_MMU = 4'hE;
   localparam group_t GROUP_RR  = 4'hD;

   // cfg block sits at dstaddr bits 10:9 == 01, bit 8 picks tx or rx
   localparam logic [1:0] CFG_SUBGROUP = 2'b01;

   // config register file
   localparam logic [31:0] CFG_VERSION = 32'h0001_0203;
   localparam int CFG_NREGS = 8;
   localparam int CFG_IDX_W = $clog2(CFG_NREGS);
   localparam logic [CFG_IDX_W-1:0] CFG_REG_VERSION = '0;

   // translation table
   localparam int MMU_ENTRIES = 16;
   localparam int MMU_IDX_W = $clog2(MMU_ENTRIES);

endpackage

`default_nettype wire

// File: hw/ecfg_cfg_regs.sv
// link configuration register file with a read-only version register at offset 0
`default_nettype none

module ecfg_cfg_regs (
   input  wire logic                       clk,
   input  wire logic                       nreset,
   // block select from the decoder
   input  wire logic                       en,
   // downstream back-pressure
   input  wire logic                       wait_in,
   // shared register bus request
   input  wire ecfg_regmap_pkg::mi_req_t   mi_req,
   // registered readback
   output ecfg_regmap_pkg::mi_data_t       dout
);

   import emesh_pkg::*;
   import ecfg_regmap_pkg::*;

   data_t                regs [CFG_NREGS];
   logic [CFG_IDX_W-1:0] idx;
   logic                 wr_en;
   logic                 rd_en;

   // one 32-bit register per 8-byte slot
   assign idx = mi_req.addr[3 +: CFG_IDX_W];

   // writes only land on an accepted cycle
   assign wr_en = en & mi_req.we & ~wait_in;

   assign rd_en = en & ~mi_req.we;

   // register array
   // version slot loads its constant and never takes a write
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < CFG_NREGS; i++)
         begin
            regs[i] <= '0;
         end
         regs[CFG_REG_VERSION] <= CFG_VERSION;
      end
      else if (wr_en && (idx != CFG_REG_VERSION))
      begin
         // low half of the bus word only
         regs[idx] <= mi_req.din[DW-1:0];
      end
   end

   // readback, one cycle after the read select
   // zero when not read so the decoder can or the blocks
   // held during wait so the reply survives a stall
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         dout <= '0;
      else if (!wait_in)
      begin
         if (rd_en)
            dout <= {{(MI_DW-DW){1'b0}}, regs[idx]};
         else
            dout <= '0;
      end
   end

endmodule

`default_nettype wire

// File: hw/ecfg_mmu_table.sv
// address translation table of 64-bit entries on the register bus
`default_nettype none

module ecfg_mmu_table (
   input  wire logic                       clk,
   input  wire logic                       nreset,
   // block select from the decoder
   input  wire logic                       en,
   // downstream back-pressure
   input  wire logic                       wait_in,
   // shared register bus request
   input  wire ecfg_regmap_pkg::mi_req_t   mi_req,
   // registered readback
   output ecfg_regmap_pkg::mi_data_t       dout
);

   import ecfg_regmap_pkg::*;

   mi_data_t             table_q [MMU_ENTRIES];
   logic [MMU_IDX_W-1:0] idx;
   logic                 wr_en;
   logic                 rd_en;

   // entries on 8-byte boundaries
   assign idx = mi_req.addr[3 +: MMU_IDX_W];

   // suppressed while the output is stalled
   assign wr_en = en & mi_req.we & ~wait_in;

   assign rd_en = en & ~mi_req.we;

   // translation entries, whole bus word per write
   // srcaddr half of the write holds the upper entry bits
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < MMU_ENTRIES; i++)
         begin
            table_q[i] <= '0;
         end
      end
      else if (wr_en)
         table_q[idx] <= mi_req.din;
   end

   // registered read
   // zero when idle, frozen during wait
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         dout <= '0;
      else if (!wait_in)
         dout <= rd_en ? table_q[idx] : '0;
   end

endmodule

`default_nettype wire

// File: hw/ecfg_if.sv
// register access decoder that claims mesh packets, drives the register bus and builds replies
`default_nettype none

module ecfg_if #(
   // 0 for the transmit side, 1 for the receive side
   parameter bit RX = 1'b0
) (
   input  wire logic                       clk,
   input  wire logic                       nreset,
   // incoming packet
   input  wire logic                       access_in,
   input  wire emesh_pkg::emesh_packet_t   packet_in,
   input  wire logic                       wait_in,
   // register bus
   output ecfg_regmap_pkg::mi_req_t        mi_req,
   output logic                            cfg_en,
   output logic                            mmu_en,
   input  wire ecfg_regmap_pkg::mi_data_t  cfg_dout,
   input  wire ecfg_regmap_pkg::mi_data_t  mmu_dout,
   // outgoing packet
   output logic                            access_out,
   output emesh_pkg::emesh_packet_t        packet_out
);

   import emesh_pkg::*;
   import ecfg_regmap_pkg::*;

   group_t        group;
   logic          match;
   logic          mi_en;
   logic          mi_rd;
   logic          fwd;
   logic          rd_q;
   mi_data_t      dout_mux;
   addr_t         rsp_dstaddr_q;
   datamode_t     rsp_datamode_q;
   ctrlmode_t     rsp_ctrlmode_q;
   emesh_packet_t rsp_packet;

   // address group of the incoming packet
   assign group = packet_in.dstaddr[19:16];

   // packet is for this chip
   assign match = access_in & (packet_in.dstaddr[31:20] == CHIP_ID);

   // config block, group mmr with bits 10:8 == 01 then rx
   assign cfg_en = match
                   & (group == GROUP_MMR)
                   & (packet_in.dstaddr[10:8] == {CFG_SUBGROUP, RX});

   // mmu table, bit 15 picks tx or rx half
   assign mmu_en = match
                   & (group == GROUP_MMU)
                   & (packet_in.dstaddr[15] == RX);

   assign mi_en = cfg_en | mmu_en;
   assign mi_rd = mi_en & ~packet_in.write;

   // claimed groups not served here go out untouched
   // covers remote reads and the other direction's registers
   assign fwd = match & ~mi_en
                & ((group == GROUP_RR) | (group == GROUP_MMR) | (group == GROUP_MMU));

   // one request struct to both blocks
   // blocks qualify it with their own select
   assign mi_req.we   = packet_in.write;
   assign mi_req.addr = packet_in.dstaddr[MI_AW-1:0];
   assign mi_req.din  = {packet_in.srcaddr, packet_in.data};

   // unselected blocks return zero, so or is enough
   assign dout_mux = cfg_dout | mmu_dout;

   // read pending, one stage while the blocks fetch
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rd_q <= 1'b0;
      else if (!wait_in)
         rd_q <= mi_rd;
   end

   // reply header fields from the request
   // reply goes back to the requester
   always_ff @(posedge clk)
   begin
      if (!wait_in)
      begin
         rsp_dstaddr_q  <= packet_in.srcaddr;
         rsp_datamode_q <= packet_in.datamode;
         rsp_ctrlmode_q <= packet_in.ctrlmode;
      end
   end

   // reply is a write carrying the readback
   // upper readback half rides in srcaddr
   always_comb
   begin
      rsp_packet.srcaddr  = dout_mux[MI_DW-1:DW];
      rsp_packet.data     = dout_mux[DW-1:0];
      rsp_packet.dstaddr  = rsp_dstaddr_q;
      rsp_packet.rsvd     = 1'b0;
      rsp_packet.ctrlmode = rsp_ctrlmode_q;
      rsp_packet.datamode = rsp_datamode_q;
      rsp_packet.write    = 1'b1;
   end

   // output valid, frozen while downstream waits
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else if (!wait_in)
         access_out <= fwd | rd_q;
   end

   // output packet
   // a forward right behind a read shares its slot, the reply takes it
   always_ff @(posedge clk)
   begin
      if (!wait_in)
         packet_out <= rd_q ? rsp_packet : packet_in;
   end

endmodule

`default_nettype wire

// File: hw/ecfg_top.sv
// transmit-side link configuration front end with decoder, register file and mmu table
`default_nettype none

module ecfg_top (
   input  wire logic                      clk,
   input  wire logic                      nreset,
   // packets from the mesh
   input  wire logic                      access_in,
   input  wire emesh_pkg::emesh_packet_t  packet_in,
   // back-pressure from the output side
   input  wire logic                      wait_in,
   // replies and forwarded packets
   output wire logic                      access_out,
   output wire emesh_pkg::emesh_packet_t  packet_out,
   // back-pressure to the sender
   output wire logic                      wait_out
);

   import ecfg_regmap_pkg::*;

   wire mi_req_t  mi_req;
   wire logic     cfg_en;
   wire logic     mmu_en;
   wire mi_data_t cfg_dout;
   wire mi_data_t mmu_dout;

   // no buffering, the sender sees the output stall directly
   assign wait_out = wait_in;

   // packet decoder, tx side
   ecfg_if #(
      .RX (1'b0)
   ) ecfg_if0 (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .mi_req     (mi_req),
      .cfg_en     (cfg_en),
      .mmu_en     (mmu_en),
      .cfg_dout   (cfg_dout),
      .mmu_dout   (mmu_dout),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   // config registers
   ecfg_cfg_regs ecfg_cfg_regs0 (
      .clk     (clk),
      .nreset  (nreset),
      .en      (cfg_en),
      .wait_in (wait_in),
      .mi_req  (mi_req),
      .dout    (cfg_dout)
   );

   // translation table
   ecfg_mmu_table ecfg_mmu_table0 (
      .clk     (clk),
      .nreset  (nreset),
      .en      (mmu_en),
      .wait_in (wait_in),
      .mi_req  (mi_req),
      .dout    (mmu_dout)
   );

endmodule

`default_nettype wire

// File: tb/ecfg_asserts.sv
// bound checks on the decoder register bus selects and output handshake
`default_nettype none

module ecfg_asserts (
   input  wire logic                      clk,
   input  wire logic                      nreset,
   input  wire logic                      cfg_en,
   input  wire logic                      mmu_en,
   input  wire logic                      wait_in,
   input  wire logic                      access_out,
   input  wire emesh_pkg::emesh_packet_t  packet_out
);

   timeunit 1ns;
   timeprecision 1ps;

   // never both register blocks on one request
   one_select: assert property (@(posedge clk) disable iff (!nreset)
      !(cfg_en && mmu_en))
      else $error("cfg and mmu selects high together");

   // no output while in reset or on the first cycle out of it
   idle_after_reset: assert property (@(posedge clk)
      (!nreset || $rose(nreset)) |-> !access_out)
      else $error("access_out high right after reset");

   // stalled output must not move
   hold_on_wait: assert property (@(posedge clk) disable iff (!nreset)
      (wait_in && access_out) |=> ($stable(packet_out) && access_out))
      else $error("output packet changed while wait_in was high");

endmodule

`default_nettype wire

// File: tb/ecfg_tb.sv
// testbench for the link config front end, stimulus and expected replies from a test file
`default_nettype none

module ecfg_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import emesh_pkg::*;

   localparam int MAX_TESTS = 64;

   logic          clk = 1'b0;
   logic          nreset;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_in;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_out;

   // test table loaded from the data file
   string         names [MAX_TESTS];
   emesh_packet_t in_pkt [MAX_TESTS];
   emesh_packet_t out_pkt [MAX_TESTS];
   logic          rand_wait [MAX_TESTS];
   logic          out_valid [MAX_TESTS];
   int            ntests = 0;

   // replies still owed by the dut, in request order
   emesh_packet_t exp_pkt_q [$];
   string         exp_name_q [$];
   emesh_packet_t exp_pkt;
   string         exp_name;

   // test whose packet is on the input
   string         cur_name = "reset";

   int            errors = 0;
   int            checks = 0;
   int            cycle_count = 0;
   int            cycle_limit = 100;
   logic [31:0]   lfsr_state = 32'h665aa6ff;

   ecfg_top dut0 (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_out   (wait_out)
   );

   bind ecfg_if ecfg_asserts ecfg_asserts0 (
      .clk        (clk),
      .nreset     (nreset),
      .cfg_en     (cfg_en),
      .mmu_en     (mmu_en),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   // 4 ns clock
   always
   begin
      #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // one lfsr bit per stall decision
   task automatic set_wait(input logic rnd);
      if (rnd)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         wait_in <= lfsr_state[0];
      end
      else
         wait_in <= 1'b0;
   endtask

   task automatic load_tests();
      int          fd;
      int          n;
      string       line;
      string       name;
      logic [31:0] col [14];
      fd = $fopen("tb/ecfg_tests.txt", "r");
      assert (fd != 0)
      else
      begin
         errors++;
         $display("could not open the test file tb/ecfg_tests.txt");
      end
      if (fd != 0)
      begin
         while ($fgets(line, fd) != 0 && ntests < MAX_TESTS)
         begin
            // skip comments and blank lines
            if (line.len() >= 2 && line[0] != "#")
            begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                  col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                  col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
               assert (n == 15)
               else
               begin
                  errors++;
                  $display("test line could not be parsed: %0s", line);
               end
               if (n == 15)
               begin
                  names[ntests] = name;
                  in_pkt[ntests] = '0;
                  in_pkt[ntests].write = col[0][0];
                  in_pkt[ntests].datamode = col[1][1:0];
                  in_pkt[ntests].ctrlmode = col[2][3:0];
                  in_pkt[ntests].dstaddr = col[3];
                  in_pkt[ntests].data = col[4];
                  in_pkt[ntests].srcaddr = col[5];
                  rand_wait[ntests] = col[6][0];
                  out_valid[ntests] = col[7][0];
                  out_pkt[ntests] = '0;
                  out_pkt[ntests].write = col[8][0];
                  out_pkt[ntests].datamode = col[9][1:0];
                  out_pkt[ntests].ctrlmode = col[10][3:0];
                  out_pkt[ntests].dstaddr = col[11];
                  out_pkt[ntests].data = col[12];
                  out_pkt[ntests].srcaddr = col[13];
                  ntests++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // present one packet, hold it until a cycle without wait takes it
   task automatic send_packet(input int n);
      logic accepted;
      cur_name = names[n];
      access_in <= 1'b1;
      packet_in <= in_pkt[n];
      set_wait(rand_wait[n]);
      if (out_valid[n])
      begin
         exp_pkt_q.push_back(out_pkt[n]);
         exp_name_q.push_back(names[n]);
      end
      accepted = 1'b0;
      while (!accepted)
      begin
         @(posedge clk);
         if (!wait_in)
            accepted = 1'b1;
         else
            set_wait(rand_wait[n]);
      end
   endtask

   // output taken on cycles with access_out and no wait
   always @(posedge clk)
   begin
      if (nreset && access_out && !wait_in)
      begin
         assert (exp_pkt_q.size() > 0)
         else
         begin
            errors++;
            $display("output packet %h arrived with no reply pending", packet_out);
         end
         if (exp_pkt_q.size() > 0)
         begin
            exp_pkt = exp_pkt_q.pop_front();
            exp_name = exp_name_q.pop_front();
            checks++;
            assert (packet_out == exp_pkt)
            else
            begin
               errors++;
               $display("** Error: %0s expected %h actual %h", exp_name, exp_pkt, packet_out);
            end
         end
      end
   end

   // stall goes straight back to the sender
   always @(negedge clk)
   begin
      checks++;
      assert (wait_out === wait_in)
      else
      begin
         errors++;
         $display("** Error: %0s wait_out expected %b actual %b", cur_name, wait_in, wait_out);
      end
   end

   initial
   begin
      wait (cycle_count >= cycle_limit);
      $display("timeout after %0d cycles with %0d replies missing",
         cycle_count, exp_pkt_q.size());
      $display("%0d checks, %0d errors", checks, errors);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      int idx;
      nreset = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in = 1'b0;
      load_tests();
      cycle_limit = ntests * 8 + 100;
      repeat (10) @(posedge clk);
      nreset <= 1'b1;
      repeat (2) @(posedge clk);
      for (idx = 0; idx < ntests; idx++)
      begin
         send_packet(idx);
      end
      access_in <= 1'b0;
      wait_in <= 1'b0;
      // drain, then a few idle cycles to catch extra packets
      while (exp_pkt_q.size() > 0)
         @(posedge clk);
      repeat (4) @(posedge clk);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/ecfg_tests.txt
# name wr dm cm dstaddr data srcaddr randwait | out o_wr o_dm o_cm o_dstaddr o_data o_srcaddr
# all values hex, out 0 means no packet expected and the output columns are ignored
cfg_wr1   1 2 0 810f0208 cafe0001 00000000 0  0 0 0 0 00000000 00000000 00000000
cfg_rd1   0 2 0 810f0208 00000000 810d1000 0  1 1 2 0 810d1000 cafe0001 00000000
cfg_wr3   1 2 0 810f0218 12345678 0000abcd 0  0 0 0 0 00000000 00000000 00000000
cfg_rd3   0 2 5 810f0218 00000000 810d2000 0  1 1 2 5 810d2000 12345678 00000000
ver_wr    1 2 0 810f0200 ffffffff 00000000 0  0 0 0 0 00000000 00000000 00000000
ver_rd    0 2 0 810f0200 00000000 810d3000 0  1 1 2 0 810d3000 00010203 00000000
mmu_wr5   1 3 0 810e0028 89abcdef 01234567 0  0 0 0 0 00000000 00000000 00000000
mmu_rd5   0 3 0 810e0028 00000000 810d4000 0  1 1 3 0 810d4000 89abcdef 01234567
drop_id   1 2 0 820d0040 55555555 810d5000 0  0 0 0 0 00000000 00000000 00000000
rr_fwd    0 2 3 810d0040 aaaa0000 810d6000 0  1 0 2 3 810d0040 aaaa0000 810d6000
rxcfg_fwd 1 2 0 810f0308 11112222 810d7000 0  1 1 2 0 810f0308 11112222 810d7000
rxmmu_fwd 1 3 0 810e8010 33334444 55556666 0  1 1 3 0 810e8010 33334444 55556666
mmu_wr15  1 3 0 810e0078 deadbeef feedf00d 1  0 0 0 0 00000000 00000000 00000000
cfg_wr7   1 2 0 810f0238 0badc0de 00000000 1  0 0 0 0 00000000 00000000 00000000
mmu_rd15  0 3 1 810e0078 00000000 810d8000 1  1 1 3 1 810d8000 deadbeef feedf00d
cfg_rd7   0 2 2 810f0238 00000000 810d9000 1  1 1 2 2 810d9000 0badc0de 00000000
ver_rd2   0 0 0 810f0200 00000000 810da000 1  1 1 0 0 810da000 00010203 00000000
cfg_rd1b  0 1 0 810f0208 00000000 810db000 1  1 1 1 0 810db000 cafe0001 00000000
mmu_rd5b  0 3 0 810e0028 00000000 810dc000 1  1 1 3 0 810dc000 89abcdef 01234567
mmu_wr5b  1 3 0 810e0028 00000001 00000002 1  0 0 0 0 00000000 00000000 00000000
mmu_rd5c  0 3 0 810e0028 00000000 810dd000 1  1 1 3 0 810dd000 00000001 00000002
drop_id2  0 2 0 000d0040 00000000 810de000 1  0 0 0 0 00000000 00000000 00000000
rr_fwd2   1 2 0 810d0080 99998888 77776666 1  1 1 2 0 810d0080 99998888 77776666
cfg_wr2   1 2 0 810f0210 abcd0123 00000000 1  0 0 0 0 00000000 00000000 00000000
cfg_rd2   0 2 0 810f0210 00000000 810df000 1  1 1 2 0 810df000 abcd0123 00000000

// File: files.f
hw/emesh_pkg.sv
hw/ecfg_regmap_pkg.sv
hw/ecfg_cfg_regs.sv
hw/ecfg_mmu_table.sv
hw/ecfg_if.sv
hw/ecfg_top.sv
tb/ecfg_asserts.sv
tb/ecfg_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ecfg testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module ecfg_tb -o ecfg_sim -f files.f

out=$(./obj_dir/ecfg_sim)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
   exit 0
else
   exit 1
fi
